// ==== hdl/ipcp_macros.svh ====
`ifndef IPCP_MACROS_SVH
`define IPCP_MACROS_SVH

// IP table, indexed by IP bits 7:2, tagged by IP bits 16:8.
`define IPCP_IP_IDX_W 6
`define IPCP_IP_IDX_LSB 2
`define IPCP_IP_TAG_W 9
`define IPCP_IP_TAG_LSB 8

// Region table, one entry per 4 KB region.
`define IPCP_RST_IDX_W 4
`define IPCP_RST_IDX_LSB 12
`define IPCP_RST_TAG_W 9
`define IPCP_RST_TAG_LSB 16

// 64-byte lines, 64 lines per region.
`define IPCP_LINE_LSB 6
`define IPCP_LINE_W 9
`define IPCP_OFFSET_W 6

`define IPCP_DENSE_THRESH 48
`define IPCP_FIFO_DEPTH 4

`endif

// ==== hdl/ipcpPkg.sv ====
`include "ipcp_macros.svh"

package ipcpPkg;

    // Code 2 is not used.
    typedef enum logic [1:0] {
        NL = 2'd0,
        CS = 2'd1,
        GS = 2'd3
    } pfClassE;

    typedef struct packed {
        logic [31:0] ip;
        logic [31:0] addr;
    } visitS;

    typedef struct packed {
        logic [`IPCP_IP_TAG_W-1:0] tag;
        logic                      valid;
        logic [`IPCP_LINE_W-1:0]   lastLine;
        logic signed [7:0]         stride;
        logic [1:0]                conf;
    } ipEntryS;

    typedef struct packed {
        logic [`IPCP_RST_TAG_W-1:0]       tag;
        logic                             valid;
        logic [(1<<`IPCP_OFFSET_W)-1:0]   lines;
        logic [`IPCP_OFFSET_W:0]          count;
        logic [`IPCP_OFFSET_W-1:0]        lastOffset;
        logic                             dirDown;
    } regionEntryS;

    typedef struct packed {
        logic dense;
        logic dirDown;
    } regionInfoS;

    // Classifier output carries the visit address; the issue stage turns it into a line target.
    typedef struct packed {
        logic [31:0]       addr;
        pfClassE           pfClass;
        logic signed [7:0] stride;
    } prefetchS;

endpackage

// ==== hdl/simpleDualBram.sv ====
`timescale 1ns/1ps

module simpleDualBram #(
    parameter int dataWidth = 32,
    parameter int addrWidth = 4
) (
    input  logic                 clk,
    input  logic [addrWidth-1:0] raddr,
    output logic [dataWidth-1:0] dout,
    input  logic [addrWidth-1:0] waddr,
    input  logic [dataWidth-1:0] din,
    input  logic                 we
);

    logic [dataWidth-1:0] mem [0:(1<<addrWidth)-1];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= din;
        end
    end

    // Read during write returns the old word.
    always_ff @(posedge clk)
    begin
        dout <= mem[raddr];
    end

endmodule

// ==== hdl/ipClassifier.sv ====
`timescale 1ns/1ps
`include "ipcp_macros.svh"

module ipClassifier (
    input  logic                clk,
    input  logic                rstn,
    input  logic                s1Valid,
    input  ipcpPkg::visitS      s1Visit,
    input  ipcpPkg::regionInfoS region,
    output logic                resValid,
    output ipcpPkg::prefetchS   res
);

    import ipcpPkg::*;

    localparam int Entries = 1 << `IPCP_IP_IDX_W;

    logic [`IPCP_IP_IDX_W-1:0] rdIdx;
    logic [`IPCP_IP_IDX_W-1:0] wrIdx;
    logic [`IPCP_IP_TAG_W-1:0] s2Tag;
    logic [`IPCP_LINE_W-1:0]   curLine;
    logic [`IPCP_LINE_W-1:0]   lineDiff;
    logic signed [7:0]         newStride;
    logic signed [7:0]         outStride;
    logic [Entries-1:0]        validQ;
    logic                      s2ValidQ;
    visitS                     s2VisitQ;
    logic                      curValidQ;
    logic                      fwdQ;
    ipEntryS                   fwdEntryQ;
    ipEntryS                   ramRd;
    ipEntryS                   cur;
    ipEntryS                   upd;
    logic                      hit;
    logic                      fwdHit;
    pfClassE                   pfClass;

    assign rdIdx = s1Visit.ip[`IPCP_IP_IDX_LSB +: `IPCP_IP_IDX_W];
    assign wrIdx = s2VisitQ.ip[`IPCP_IP_IDX_LSB +: `IPCP_IP_IDX_W];
    assign s2Tag = s2VisitQ.ip[`IPCP_IP_TAG_LSB +: `IPCP_IP_TAG_W];
    assign curLine = s2VisitQ.addr[`IPCP_LINE_LSB +: `IPCP_LINE_W];

    // Entry being written now is the one stage 1 asks for.
    assign fwdHit = s2ValidQ && (wrIdx == rdIdx);

    simpleDualBram #(
        .dataWidth($bits(ipEntryS)),
        .addrWidth(`IPCP_IP_IDX_W)
    ) ipRam (
        .clk  (clk),
        .raddr(rdIdx),
        .dout (ramRd),
        .waddr(wrIdx),
        .din  (upd),
        .we   (s2ValidQ)
    );

    always_comb
    begin
        cur = fwdQ ? fwdEntryQ : ramRd;
        cur.valid = curValidQ;
    end

    assign hit = cur.valid && (cur.tag == s2Tag);
    assign lineDiff = curLine - cur.lastLine;
    assign newStride = lineDiff[7:0];

    always_comb
    begin
        upd = cur;
        upd.valid = 1'b1;
        upd.lastLine = curLine;
        if (!hit)
        begin
            upd.tag = s2Tag;
            upd.stride = '0;
            upd.conf = '0;
        end
        else
        begin
            if (newStride == cur.stride)
            begin
                if (cur.conf != 2'd3)
                    upd.conf = cur.conf + 2'd1;
            end
            else if (cur.conf != 2'd0)
            begin
                upd.conf = cur.conf - 2'd1;
            end
            // Stride only retrains once confidence has run out.
            if (cur.conf == 2'd0)
                upd.stride = newStride;
        end
    end

    always_comb
    begin
        if (region.dense)
        begin
            pfClass = GS;
            outStride = region.dirDown ? -8'sd1 : 8'sd1;
        end
        else if (hit && (cur.conf >= 2'd2))
        begin
            pfClass = CS;
            outStride = cur.stride;
        end
        else
        begin
            pfClass = NL;
            outStride = 8'sd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            s2ValidQ <= 1'b0;
            fwdQ <= 1'b0;
            curValidQ <= 1'b0;
            validQ <= '0;
            resValid <= 1'b0;
        end
        else
        begin
            s2ValidQ <= s1Valid;
            fwdQ <= fwdHit;
            curValidQ <= validQ[rdIdx] || fwdHit;
            if (s2ValidQ)
                validQ[wrIdx] <= 1'b1;
            resValid <= s2ValidQ;
        end
    end

    always_ff @(posedge clk)
    begin
        s2VisitQ <= s1Visit;
        fwdEntryQ <= upd;
        res.addr <= s2VisitQ.addr;
        res.pfClass <= pfClass;
        res.stride <= outStride;
    end

    resValidKnown: assert property (@(posedge clk) disable iff (!rstn) !$isunknown(resValid))
        else $error("resValid is unknown");

endmodule

// ==== hdl/regionStreamTable.sv ====
`timescale 1ns/1ps
`include "ipcp_macros.svh"

module regionStreamTable (
    input  logic                clk,
    input  logic                rstn,
    input  logic                s1Valid,
    input  ipcpPkg::visitS      s1Visit,
    output ipcpPkg::regionInfoS region
);

    import ipcpPkg::*;

    localparam int Entries = 1 << `IPCP_RST_IDX_W;

    logic [`IPCP_RST_IDX_W-1:0] rdIdx;
    logic [`IPCP_RST_IDX_W-1:0] wrIdx;
    logic [`IPCP_RST_TAG_W-1:0] s2Tag;
    logic [`IPCP_OFFSET_W-1:0]  offset;
    logic [Entries-1:0]         validQ;
    logic                       s2ValidQ;
    visitS                      s2VisitQ;
    logic                       curValidQ;
    logic                       fwdQ;
    regionEntryS                fwdEntryQ;
    regionEntryS                ramRd;
    regionEntryS                cur;
    regionEntryS                upd;
    logic                       hit;
    logic                       fwdHit;

    assign rdIdx = s1Visit.addr[`IPCP_RST_IDX_LSB +: `IPCP_RST_IDX_W];
    assign wrIdx = s2VisitQ.addr[`IPCP_RST_IDX_LSB +: `IPCP_RST_IDX_W];
    assign s2Tag = s2VisitQ.addr[`IPCP_RST_TAG_LSB +: `IPCP_RST_TAG_W];
    assign offset = s2VisitQ.addr[`IPCP_LINE_LSB +: `IPCP_OFFSET_W];
    assign fwdHit = s2ValidQ && (wrIdx == rdIdx);

    simpleDualBram #(
        .dataWidth($bits(regionEntryS)),
        .addrWidth(`IPCP_RST_IDX_W)
    ) regionRam (
        .clk  (clk),
        .raddr(rdIdx),
        .dout (ramRd),
        .waddr(wrIdx),
        .din  (upd),
        .we   (s2ValidQ)
    );

    always_comb
    begin
        cur = fwdQ ? fwdEntryQ : ramRd;
        cur.valid = curValidQ;
    end

    assign hit = cur.valid && (cur.tag == s2Tag);

    always_comb
    begin
        upd = cur;
        upd.valid = 1'b1;
        upd.lastOffset = offset;
        if (!hit)
        begin
            upd.tag = s2Tag;
            upd.lines = '0;
            upd.lines[offset] = 1'b1;
            upd.count = 7'd1;
            upd.dirDown = 1'b0;
        end
        else
        begin
            upd.lines[offset] = 1'b1;
            if (!cur.lines[offset])
                upd.count = cur.count + 7'd1;
            // Same offset keeps the old direction.
            if (offset < cur.lastOffset)
                upd.dirDown = 1'b1;
            else if (offset > cur.lastOffset)
                upd.dirDown = 1'b0;
        end
    end

    assign region.dense = (upd.count >= 7'(`IPCP_DENSE_THRESH));
    assign region.dirDown = upd.dirDown;

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            s2ValidQ <= 1'b0;
            fwdQ <= 1'b0;
            curValidQ <= 1'b0;
            validQ <= '0;
        end
        else
        begin
            s2ValidQ <= s1Valid;
            fwdQ <= fwdHit;
            curValidQ <= validQ[rdIdx] || fwdHit;
            if (s2ValidQ)
                validQ[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        s2VisitQ <= s1Visit;
        fwdEntryQ <= upd;
    end

    countInRange: assert property (@(posedge clk) disable iff (!rstn)
        s2ValidQ |-> (upd.count <= 7'd64))
        else $error("region line count above 64");

endmodule

// ==== hdl/prefetchIssue.sv ====
`timescale 1ns/1ps
`include "ipcp_macros.svh"

module prefetchIssue (
    input  logic              clk,
    input  logic              rstn,
    input  logic              accept,
    input  logic              resValid,
    input  ipcpPkg::prefetchS res,
    output logic              visitReady,
    output logic              pfValid,
    input  logic              pfReady,
    output ipcpPkg::prefetchS pf
);

    import ipcpPkg::*;

    localparam int PtrW = $clog2(`IPCP_FIFO_DEPTH);
    localparam int CntW = PtrW + 1;
    localparam int LineW = 32 - `IPCP_LINE_LSB;

    prefetchS         fifoMem [`IPCP_FIFO_DEPTH];
    logic [PtrW-1:0]  wrPtr;
    logic [PtrW-1:0]  rdPtr;
    logic [CntW-1:0]  fifoCount;
    logic [CntW-1:0]  usedCredits;
    logic [LineW-1:0] baseLine;
    logic [LineW-1:0] targetLine;
    logic             pop;
    prefetchS         issued;

    always_comb
    begin
        baseLine = res.addr[31:`IPCP_LINE_LSB];
        case (res.pfClass)
            CS:      targetLine = baseLine + {{(LineW-8){res.stride[7]}}, res.stride};
            GS:      targetLine = res.stride[7] ? baseLine - LineW'(1) : baseLine + LineW'(1);
            default: targetLine = baseLine + LineW'(1);
        endcase
        issued.addr = {targetLine, {`IPCP_LINE_LSB{1'b0}}};
        issued.pfClass = res.pfClass;
        issued.stride = res.stride;
    end

    assign pop = pfValid && pfReady;
    assign pfValid = (fifoCount != '0);
    assign pf = fifoMem[rdPtr];

    // A credit is taken at acceptance and returned when the prefetch leaves.
    assign visitReady = (usedCredits < CntW'(`IPCP_FIFO_DEPTH));

    always_ff @(posedge clk)
    begin
        if (resValid)
            fifoMem[wrPtr] <= issued;
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            fifoCount <= '0;
            usedCredits <= '0;
        end
        else
        begin
            if (resValid)
                wrPtr <= wrPtr + PtrW'(1);
            if (pop)
                rdPtr <= rdPtr + PtrW'(1);
            fifoCount <= fifoCount + CntW'(resValid) - CntW'(pop);
            usedCredits <= usedCredits + CntW'(accept) - CntW'(pop);
        end
    end

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstn)
        resValid |-> (fifoCount < CntW'(`IPCP_FIFO_DEPTH)))
        else $error("result pushed into full FIFO");

    pfStableWhenStalled: assert property (@(posedge clk) disable iff (!rstn)
        (pfValid && !pfReady) |=> (pfValid && $stable(pf)))
        else $error("pf changed while stalled");

endmodule

// ==== hdl/ipcpTop.sv ====
`timescale 1ns/1ps

module ipcpTop (
    input  logic              clk,
    input  logic              rstn,
    input  logic              visitValid,
    output logic              visitReady,
    input  ipcpPkg::visitS    visit,
    output logic              pfValid,
    input  logic              pfReady,
    output ipcpPkg::prefetchS pf
);

    import ipcpPkg::*;

    logic       accept;
    logic       s1Valid;
    visitS      s1Visit;
    regionInfoS region;
    logic       resValid;
    prefetchS   res;

    assign accept = visitValid && visitReady;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            s1Valid <= 1'b0;
        else
            s1Valid <= accept;
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            s1Visit <= visit;
    end

    regionStreamTable regionTable (
        .clk    (clk),
        .rstn   (rstn),
        .s1Valid(s1Valid),
        .s1Visit(s1Visit),
        .region (region)
    );

    ipClassifier classifier (
        .clk     (clk),
        .rstn    (rstn),
        .s1Valid (s1Valid),
        .s1Visit (s1Visit),
        .region  (region),
        .resValid(resValid),
        .res     (res)
    );

    prefetchIssue issue (
        .clk       (clk),
        .rstn      (rstn),
        .accept    (accept),
        .resValid  (resValid),
        .res       (res),
        .visitReady(visitReady),
        .pfValid   (pfValid),
        .pfReady   (pfReady),
        .pf        (pf)
    );

endmodule

// ==== verification/ipcpTb.sv ====
`timescale 1ns/1ps
`include "ipcp_macros.svh"

module ipcpTb;

    import ipcpPkg::*;

    localparam int PlannedVisits = 2310;
    localparam int TimeoutCycles = 20 * PlannedVisits + 200;
    localparam int LineW = 32 - `IPCP_LINE_LSB;

    logic        clk;
    logic        rstn;
    logic        visitValid;
    logic        visitReady;
    visitS       visit;
    logic        pfValid;
    logic        pfReady;
    prefetchS    pf;

    ipEntryS     ipModel [1 << `IPCP_IP_IDX_W];
    regionEntryS regionModel [1 << `IPCP_RST_IDX_W];
    prefetchS    expQ [$];
    logic        randomReady;
    logic        sawStall;
    int          cycles;
    int          credits;
    int          csSeen;
    int          gsUpSeen;
    int          gsDownSeen;
    int unsigned seedInit;

    ipcpTop dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .visitValid(visitValid),
        .visitReady(visitReady),
        .visit     (visit),
        .pfValid   (pfValid),
        .pfReady   (pfReady),
        .pf        (pf)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compareAddr(input string name, input logic [31:0] expVal,
                               input logic [31:0] gotVal);
        if (gotVal !== expVal)
            failRun($sformatf("Mismatch %s: expected %h, got %h", name, expVal, gotVal));
    endtask

    task automatic compareClass(input string name, input pfClassE expVal,
                                input pfClassE gotVal);
        if (gotVal !== expVal)
            failRun($sformatf("Mismatch %s: expected %h, got %h", name, expVal, gotVal));
    endtask

    task automatic compareStride(input string name, input logic signed [7:0] expVal,
                                 input logic signed [7:0] gotVal);
        if (gotVal !== expVal)
            failRun($sformatf("Mismatch %s: expected %h, got %h", name, expVal, gotVal));
    endtask

    task automatic compareReady(input string name, input logic expVal,
                                input logic gotVal);
        if (gotVal !== expVal)
            failRun($sformatf("Mismatch %s: expected %h, got %h", name, expVal, gotVal));
    endtask

    // Reference model of both tables, called once per accepted visit.
    function automatic prefetchS predict(input visitS v);
        logic [`IPCP_IP_IDX_W-1:0]  ipIdx;
        logic [`IPCP_RST_IDX_W-1:0] rgnIdx;
        logic [`IPCP_LINE_W-1:0]    line;
        logic [`IPCP_LINE_W-1:0]    diff;
        logic [`IPCP_OFFSET_W-1:0]  offset;
        logic signed [7:0]          newStride;
        logic signed [7:0]          oldStride;
        logic [1:0]                 oldConf;
        logic                       ipHit;
        logic                       dense;
        logic [LineW-1:0]           target;
        ipEntryS                    e;
        regionEntryS                r;
        prefetchS                   p;

        ipIdx = v.ip[`IPCP_IP_IDX_LSB +: `IPCP_IP_IDX_W];
        rgnIdx = v.addr[`IPCP_RST_IDX_LSB +: `IPCP_RST_IDX_W];
        line = v.addr[`IPCP_LINE_LSB +: `IPCP_LINE_W];
        offset = v.addr[`IPCP_LINE_LSB +: `IPCP_OFFSET_W];

        // Region first. Its updated count decides density.
        r = regionModel[rgnIdx];
        if (!r.valid || (r.tag != v.addr[`IPCP_RST_TAG_LSB +: `IPCP_RST_TAG_W]))
        begin
            r.tag = v.addr[`IPCP_RST_TAG_LSB +: `IPCP_RST_TAG_W];
            r.lines = '0;
            r.count = 7'd1;
            r.dirDown = 1'b0;
        end
        else
        begin
            if (!r.lines[offset])
                r.count = r.count + 7'd1;
            if (offset < r.lastOffset)
                r.dirDown = 1'b1;
            else if (offset > r.lastOffset)
                r.dirDown = 1'b0;
        end
        r.lines[offset] = 1'b1;
        r.valid = 1'b1;
        r.lastOffset = offset;
        regionModel[rgnIdx] = r;
        dense = (r.count >= 7'(`IPCP_DENSE_THRESH));

        e = ipModel[ipIdx];
        ipHit = e.valid && (e.tag == v.ip[`IPCP_IP_TAG_LSB +: `IPCP_IP_TAG_W]);
        oldConf = e.conf;
        oldStride = e.stride;
        diff = line - e.lastLine;
        newStride = diff[7:0];
        if (!ipHit)
        begin
            e.tag = v.ip[`IPCP_IP_TAG_LSB +: `IPCP_IP_TAG_W];
            e.stride = 8'sd0;
            e.conf = 2'd0;
        end
        else
        begin
            if (newStride == e.stride)
            begin
                if (e.conf != 2'd3)
                    e.conf = e.conf + 2'd1;
            end
            else if (e.conf != 2'd0)
            begin
                e.conf = e.conf - 2'd1;
            end
            if (oldConf == 2'd0)
                e.stride = newStride;
        end
        e.valid = 1'b1;
        e.lastLine = line;
        ipModel[ipIdx] = e;

        if (dense)
        begin
            p.pfClass = GS;
            p.stride = r.dirDown ? -8'sd1 : 8'sd1;
        end
        else if (ipHit && (oldConf >= 2'd2))
        begin
            p.pfClass = CS;
            p.stride = oldStride;
        end
        else
        begin
            p.pfClass = NL;
            p.stride = 8'sd1;
        end
        // Signed step in lines, one for NL.
        target = v.addr[31:`IPCP_LINE_LSB] + {{(LineW-8){p.stride[7]}}, p.stride};
        p.addr = {target, {`IPCP_LINE_LSB{1'b0}}};
        return p;
    endfunction

    function automatic visitS randomVisit();
        visitS v;
        v.ip = 32'h0040_0000 | (($urandom % 4) << 8) | (($urandom % 8) << 2);
        if (($urandom % 8) == 0)
            v.addr = $urandom;
        else
            v.addr = 32'h0600_0000 | (($urandom % 2) << 16) | (($urandom % 4) << 12)
                | (($urandom % 64) << 6) | ($urandom % 64);
        return v;
    endfunction

    // Returns once the visit is sure to be taken at the next rising edge.
    task automatic sendVisit(input logic [31:0] ip, input logic [31:0] addr, input int gap);
        @(negedge clk);
        if (gap > 0)
        begin
            visitValid = 1'b0;
            repeat (gap) @(negedge clk);
        end
        visitValid = 1'b1;
        visit.ip = ip;
        visit.addr = addr;
        while (!visitReady)
            @(negedge clk);
    endtask

    always @(negedge clk)
    begin
        if (randomReady)
            pfReady = 1'($urandom % 2);
        else
            pfReady = 1'b1;
    end

    always @(posedge clk)
    begin
        prefetchS expected;
        if (rstn)
        begin
            // Credits in use are visits accepted and not yet sent out.
            compareReady("visitReady", credits < `IPCP_FIFO_DEPTH, visitReady);
            if (pfValid && pfReady)
            begin
                if (expQ.size() == 0)
                    failRun("A prefetch came out with no visit waiting for one");
                else
                begin
                    expected = expQ.pop_front();
                    compareAddr("pf.addr", expected.addr, pf.addr);
                    compareClass("pf.pfClass", expected.pfClass, pf.pfClass);
                    compareStride("pf.stride", expected.stride, pf.stride);
                    if (expected.pfClass == CS)
                        csSeen++;
                    else if (expected.pfClass == GS && expected.stride[7])
                        gsDownSeen++;
                    else if (expected.pfClass == GS)
                        gsUpSeen++;
                    credits--;
                end
            end
            if (visitValid && !visitReady)
                sawStall = 1'b1;
            if (visitValid && visitReady)
            begin
                expQ.push_back(predict(visit));
                credits++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > TimeoutCycles)
            failRun($sformatf("Timeout after %0d cycles with %0d prefetches still missing",
                              cycles, expQ.size()));
    end

    initial
    begin
        visitS v;
        int    i;
        string why;

        seedInit = $urandom(32'h98793acf);
        rstn = 1'b0;
        visitValid = 1'b0;
        visit = '0;
        pfReady = 1'b1;
        randomReady = 1'b0;
        sawStall = 1'b0;
        cycles = 0;
        credits = 0;
        csSeen = 0;
        gsUpSeen = 0;
        gsDownSeen = 0;
        why = "";
        for (i = 0; i < (1 << `IPCP_IP_IDX_W); i++)
            ipModel[i] = '0;
        for (i = 0; i < (1 << `IPCP_RST_IDX_W); i++)
            regionModel[i] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // New IPs, each in a region of its own.
        for (i = 0; i < 8; i++)
            sendVisit(32'h1000_0000 + i * 32'h104, 32'h0100_0000 + i * 32'h0001_1040, 2);

        // Stride of 3 lines, then 5 lines.
        for (i = 0; i < 12; i++)
            sendVisit(32'h0000_2A40, 32'h0200_0000 + i * 3 * 64, 1);
        for (i = 1; i <= 6; i++)
            sendVisit(32'h0000_2A40, 32'h0200_0000 + (33 + i * 5) * 64, 1);

        // Fill 48 lines of one region, then walk back down.
        for (i = 0; i < 48; i++)
            sendVisit(32'h0000_3310, 32'h0330_0000 + i * 64, 0);
        for (i = 47; i >= 32; i--)
            sendVisit(32'h0000_3310, 32'h0330_0000 + i * 64 + 8, 0);

        // Same IP and region every cycle.
        for (i = 0; i < 20; i++)
            sendVisit(32'h0000_4404, 32'h0005_7000 + ((i * 5) % 64) * 64, 0);

        randomReady = 1'b1;
        for (i = 0; i < 200; i++)
        begin
            v = randomVisit();
            sendVisit(v.ip, v.addr, 0);
        end
        for (i = 0; i < 2000; i++)
        begin
            v = randomVisit();
            sendVisit(v.ip, v.addr, int'($urandom % 4));
        end

        @(negedge clk);
        visitValid = 1'b0;
        while (expQ.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);

        if (pfValid)
            why = "A prefetch is left in the output queue after the last expected one";
        else if (!sawStall)
            why = "visitReady never dropped while the output was stalled";
        else if (csSeen == 0)
            why = "No constant stride prefetch was produced";
        else if (gsUpSeen == 0 || gsDownSeen == 0)
            why = "Global stream prefetches did not cover both directions";

        if (why.len() != 0)
            failRun(why);
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/ipcpPkg.sv
hdl/simpleDualBram.sv
hdl/ipClassifier.sv
hdl/regionStreamTable.sv
hdl/prefetchIssue.sv
hdl/ipcpTop.sv
verification/ipcpTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the prefetcher testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f src.f \
    --top-module ipcpTb \
    -o ipcpSim

./obj_dir/ipcpSim
